//--- Makefile
TOP = tb_ooo_core

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert --top-module $(TOP) -f list.f -o sim
	@out=$$(./obj_dir/sim); echo "$$out"; echo "$$out" | grep -q "Test passed"

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f list.f

clean:
	rm -rf obj_dir

//--- alu_unit.sv
`timescale 1ns/100ps

module alu_unit import ooo_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  rdy,
    input  logic  clr,
    input  logic  ex_issue_en,
    input  op_e   ex_op,
    input  addr_t ex_pc,
    input  imm_t  ex_imm,
    input  nick_t ex_rd_nick,
    input  data_t ex_rs1_dt,
    input  data_t ex_rs2_dt,
    output logic  ex_en,
    output nick_t ex_nick,
    output data_t ex_dt
);

    data_t result;

    always_comb begin
        case (ex_op)
            ADD:     result = ex_rs1_dt + ex_rs2_dt;
            SUB:     result = ex_rs1_dt - ex_rs2_dt;
            AND:     result = ex_rs1_dt & ex_rs2_dt;
            OR:      result = ex_rs1_dt | ex_rs2_dt;
            XOR:     result = ex_rs1_dt ^ ex_rs2_dt;
            SLL:     result = ex_rs1_dt << ex_rs2_dt[4:0];
            SRL:     result = ex_rs1_dt >> ex_rs2_dt[4:0];
            SLT:     result = data_t'($signed(ex_rs1_dt) < $signed(ex_rs2_dt));
            ADDI:    result = ex_rs1_dt + data_t'(ex_imm);
            LUI:     result = data_t'(ex_imm);
            AUIPC:   result = data_t'(ex_pc + addr_t'(ex_imm));
            default: result = '0;
        endcase
    end

    // one-cycle broadcast strobe
    always_ff @(posedge clk) begin
        if (rst || clr) begin
            ex_en <= 1'b0;
        end else if (rdy) begin
            ex_en <= ex_issue_en;
        end
    end

    always_ff @(posedge clk) begin
        if (rdy && ex_issue_en) begin
            ex_nick <= ex_rd_nick;
            ex_dt   <= result;
        end
    end

    // loads and stores belong to the buffer, never to this unit
    a_issue_not_mem: assert property (@(posedge clk) disable iff (rst)
        ex_issue_en |-> !(ex_op inside {LW, SW}));

endmodule

//--- list.f
+incdir+.
ooo_pkg.sv
rs.sv
alu_unit.sv
slb.sv
ooo_core.sv
tb_ooo_core.sv

//--- ooo_core.sv
`timescale 1ns/100ps

module ooo_core import ooo_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  rdy,
    input  logic  clr,
    // dispatch
    input  logic  dp_en,
    input  op_e   dp_op,
    input  addr_t dp_pc,
    input  imm_t  dp_imm,
    input  nick_t dp_rd_nick,
    input  nick_t dp_rs1_nick,
    input  data_t dp_rs1_dt,
    input  nick_t dp_rs2_nick,
    input  data_t dp_rs2_dt,
    output logic  rs_full,
    output logic  slb_full,
    // broadcasts
    output logic  ex_en,
    output nick_t ex_nick,
    output data_t ex_dt,
    output logic  slb_en,
    output nick_t slb_nick,
    output data_t slb_dt
);

    // station to alu issue path
    logic  ex_issue_en;
    op_e   ex_op;
    addr_t ex_pc;
    imm_t  ex_imm;
    nick_t ex_rd_nick;
    data_t ex_rs1_dt;
    data_t ex_rs2_dt;

    rs u_rs (
        .clk         (clk),
        .rst         (rst),
        .rdy         (rdy),
        .clr         (clr),
        .dp_en       (dp_en),
        .dp_op       (dp_op),
        .dp_pc       (dp_pc),
        .dp_imm      (dp_imm),
        .dp_rd_nick  (dp_rd_nick),
        .dp_rs1_nick (dp_rs1_nick),
        .dp_rs1_dt   (dp_rs1_dt),
        .dp_rs2_nick (dp_rs2_nick),
        .dp_rs2_dt   (dp_rs2_dt),
        .ex_en       (ex_en),
        .ex_nick     (ex_nick),
        .ex_dt       (ex_dt),
        .slb_en      (slb_en),
        .slb_nick    (slb_nick),
        .slb_dt      (slb_dt),
        .rs_full     (rs_full),
        .ex_issue_en (ex_issue_en),
        .ex_op       (ex_op),
        .ex_pc       (ex_pc),
        .ex_imm      (ex_imm),
        .ex_rd_nick  (ex_rd_nick),
        .ex_rs1_dt   (ex_rs1_dt),
        .ex_rs2_dt   (ex_rs2_dt)
    );

    alu_unit u_alu_unit (
        .clk         (clk),
        .rst         (rst),
        .rdy         (rdy),
        .clr         (clr),
        .ex_issue_en (ex_issue_en),
        .ex_op       (ex_op),
        .ex_pc       (ex_pc),
        .ex_imm      (ex_imm),
        .ex_rd_nick  (ex_rd_nick),
        .ex_rs1_dt   (ex_rs1_dt),
        .ex_rs2_dt   (ex_rs2_dt),
        .ex_en       (ex_en),
        .ex_nick     (ex_nick),
        .ex_dt       (ex_dt)
    );

    // memory ops need no pc
    slb u_slb (
        .clk         (clk),
        .rst         (rst),
        .rdy         (rdy),
        .clr         (clr),
        .dp_en       (dp_en),
        .dp_op       (dp_op),
        .dp_imm      (dp_imm),
        .dp_rd_nick  (dp_rd_nick),
        .dp_rs1_nick (dp_rs1_nick),
        .dp_rs1_dt   (dp_rs1_dt),
        .dp_rs2_nick (dp_rs2_nick),
        .dp_rs2_dt   (dp_rs2_dt),
        .ex_en       (ex_en),
        .ex_nick     (ex_nick),
        .ex_dt       (ex_dt),
        .slb_full    (slb_full),
        .slb_en      (slb_en),
        .slb_nick    (slb_nick),
        .slb_dt      (slb_dt)
    );

endmodule

//--- ooo_defs.svh
`ifndef OOO_DEFS_SVH
`define OOO_DEFS_SVH

// datapath widths
`define OOO_DATA_W 32
`define OOO_ADDR_W 32
`define OOO_IMM_W 32

// opcode field
`define OOO_OP_W 5

// nick width fixes the station size, slot 0 never holds an entry
`define OOO_NICK_W 4
`define OOO_RS_NUM (1 << `OOO_NICK_W)

// store/load buffer
`define OOO_SLB_NUM 4
`define OOO_SLB_PTR_W 2

// word data memory
`define OOO_MEM_WORDS 64
`define OOO_MEM_AW 6

`endif

//--- ooo_pkg.sv
`include "ooo_defs.svh"

package ooo_pkg;

    typedef logic [`OOO_DATA_W-1:0] data_t;
    typedef logic [`OOO_ADDR_W-1:0] addr_t;
    typedef logic [`OOO_IMM_W-1:0]  imm_t;
    typedef logic [`OOO_NICK_W-1:0] nick_t;

    typedef enum logic [`OOO_OP_W-1:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        SLT,
        ADDI,
        LUI,
        AUIPC,
        // memory ops go to the buffer
        LW,
        SW
    } op_e;

    // head of the store/load buffer
    typedef enum logic [1:0] {
        IDLE,
        WAIT_OPS,
        ACCESS
    } slb_state_e;

endpackage

//--- rs.sv
`timescale 1ns/100ps
`include "ooo_defs.svh"

module rs import ooo_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  rdy,
    input  logic  clr,
    // dispatch
    input  logic  dp_en,
    input  op_e   dp_op,
    input  addr_t dp_pc,
    input  imm_t  dp_imm,
    input  nick_t dp_rd_nick,
    input  nick_t dp_rs1_nick,
    input  data_t dp_rs1_dt,
    input  nick_t dp_rs2_nick,
    input  data_t dp_rs2_dt,
    // result broadcasts
    input  logic  ex_en,
    input  nick_t ex_nick,
    input  data_t ex_dt,
    input  logic  slb_en,
    input  nick_t slb_nick,
    input  data_t slb_dt,
    output logic  rs_full,
    // issue to the alu
    output logic  ex_issue_en,
    output op_e   ex_op,
    output addr_t ex_pc,
    output imm_t  ex_imm,
    output nick_t ex_rd_nick,
    output data_t ex_rs1_dt,
    output data_t ex_rs2_dt
);

    logic [`OOO_RS_NUM-1:0] occupied;
    logic [`OOO_RS_NUM-1:0] rs1_valid;
    logic [`OOO_RS_NUM-1:0] rs2_valid;

    // slot payload, indexed by destination nick
    op_e   slot_op       [`OOO_RS_NUM];
    addr_t slot_pc       [`OOO_RS_NUM];
    imm_t  slot_imm      [`OOO_RS_NUM];
    nick_t slot_rs1_nick [`OOO_RS_NUM];
    nick_t slot_rs2_nick [`OOO_RS_NUM];
    data_t slot_rs1_dt   [`OOO_RS_NUM];
    data_t slot_rs2_dt   [`OOO_RS_NUM];

    logic  dp_alu;
    logic  sel_vld;
    nick_t sel_idx;

    // does either broadcast carry this nick
    function automatic logic bus_hit(input nick_t nick);
        return (ex_en && nick == ex_nick) || (slb_en && nick == slb_nick);
    endfunction

    function automatic data_t bus_dt(input nick_t nick);
        return (ex_en && nick == ex_nick) ? ex_dt : slb_dt;
    endfunction

    assign dp_alu = dp_en && !(dp_op inside {LW, SW});

    // highest ready slot wins
    always_comb begin
        sel_vld = 1'b0;
        sel_idx = '0;
        for (int i = 1; i < `OOO_RS_NUM; i++) begin
            if (occupied[i] && rs1_valid[i] && rs2_valid[i]) begin
                sel_vld = 1'b1;
                sel_idx = nick_t'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || clr) begin
            occupied    <= '0;
            rs1_valid   <= '0;
            rs2_valid   <= '0;
            ex_issue_en <= 1'b0;
            rs_full     <= 1'b0;
        end else if (rdy) begin
            rs_full <= &occupied[`OOO_RS_NUM-1:1];

            // wakeup
            for (int i = 1; i < `OOO_RS_NUM; i++) begin
                if (occupied[i] && !rs1_valid[i] && bus_hit(slot_rs1_nick[i])) begin
                    rs1_valid[i]   <= 1'b1;
                    slot_rs1_dt[i] <= bus_dt(slot_rs1_nick[i]);
                end
                if (occupied[i] && !rs2_valid[i] && bus_hit(slot_rs2_nick[i])) begin
                    rs2_valid[i]   <= 1'b1;
                    slot_rs2_dt[i] <= bus_dt(slot_rs2_nick[i]);
                end
            end

            if (dp_alu) begin
                occupied[dp_rd_nick]      <= 1'b1;
                slot_op[dp_rd_nick]       <= dp_op;
                slot_pc[dp_rd_nick]       <= dp_pc;
                slot_imm[dp_rd_nick]      <= dp_imm;
                slot_rs1_nick[dp_rd_nick] <= dp_rs1_nick;
                slot_rs2_nick[dp_rd_nick] <= dp_rs2_nick;
                // a broadcast in the dispatch cycle is caught here
                rs1_valid[dp_rd_nick] <= (dp_rs1_nick == '0) || bus_hit(dp_rs1_nick);
                rs2_valid[dp_rd_nick] <= (dp_rs2_nick == '0) || bus_hit(dp_rs2_nick);
                slot_rs1_dt[dp_rd_nick] <= (dp_rs1_nick == '0) ? dp_rs1_dt
                                                               : bus_dt(dp_rs1_nick);
                slot_rs2_dt[dp_rd_nick] <= (dp_rs2_nick == '0) ? dp_rs2_dt
                                                               : bus_dt(dp_rs2_nick);
            end

            ex_issue_en <= sel_vld;
            if (sel_vld) begin
                // slot frees on the issue edge itself
                occupied[sel_idx] <= 1'b0;
                ex_op             <= slot_op[sel_idx];
                ex_pc             <= slot_pc[sel_idx];
                ex_imm            <= slot_imm[sel_idx];
                ex_rd_nick        <= sel_idx;
                ex_rs1_dt         <= slot_rs1_dt[sel_idx];
                ex_rs2_dt         <= slot_rs2_dt[sel_idx];
            end
        end
    end

    // dispatcher may only reuse a nick after its broadcast
    a_dp_slot_free: assert property (@(posedge clk) disable iff (rst || clr)
        rdy && dp_alu |-> !occupied[dp_rd_nick]);

    // nick 0 stands for a ready value and never names a result
    a_dp_nick_nonzero: assert property (@(posedge clk) disable iff (rst)
        rdy && dp_en |-> dp_rd_nick != '0);

endmodule

//--- slb.sv
`timescale 1ns/100ps
`include "ooo_defs.svh"

module slb import ooo_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  rdy,
    input  logic  clr,
    // dispatch
    input  logic  dp_en,
    input  op_e   dp_op,
    input  imm_t  dp_imm,
    input  nick_t dp_rd_nick,
    input  nick_t dp_rs1_nick,
    input  data_t dp_rs1_dt,
    input  nick_t dp_rs2_nick,
    input  data_t dp_rs2_dt,
    // execute broadcast
    input  logic  ex_en,
    input  nick_t ex_nick,
    input  data_t ex_dt,
    output logic  slb_full,
    // load broadcast, also used for own wakeup
    output logic  slb_en,
    output nick_t slb_nick,
    output data_t slb_dt
);

    logic [`OOO_SLB_PTR_W-1:0] head;
    logic [`OOO_SLB_PTR_W-1:0] tail;
    logic [`OOO_SLB_PTR_W:0]   count;
    slb_state_e                state;

    logic [`OOO_SLB_NUM-1:0] rs1_valid;
    logic [`OOO_SLB_NUM-1:0] rs2_valid;
    op_e   ent_op       [`OOO_SLB_NUM];
    imm_t  ent_imm      [`OOO_SLB_NUM];
    nick_t ent_rd_nick  [`OOO_SLB_NUM];
    nick_t ent_rs1_nick [`OOO_SLB_NUM];
    nick_t ent_rs2_nick [`OOO_SLB_NUM];
    data_t ent_rs1_dt   [`OOO_SLB_NUM];
    data_t ent_rs2_dt   [`OOO_SLB_NUM];

    data_t mem [`OOO_MEM_WORDS];

    logic                   dp_mem;
    logic                   pop;
    logic                   head_ready;
    data_t                  head_addr;
    logic [`OOO_MEM_AW-1:0] head_idx;

    function automatic logic bus_hit(input nick_t nick);
        return (ex_en && nick == ex_nick) || (slb_en && nick == slb_nick);
    endfunction

    function automatic data_t bus_dt(input nick_t nick);
        return (ex_en && nick == ex_nick) ? ex_dt : slb_dt;
    endfunction

    assign dp_mem = dp_en && (dp_op inside {LW, SW});
    assign pop    = (state == ACCESS);
    // a load has no second operand
    assign head_ready = rs1_valid[head] && (ent_op[head] == LW || rs2_valid[head]);
    assign head_addr  = ent_rs1_dt[head] + data_t'(ent_imm[head]);
    assign head_idx   = head_addr[`OOO_MEM_AW+1:2];

    always_ff @(posedge clk) begin
        if (rst || clr) begin
            head      <= '0;
            tail      <= '0;
            count     <= '0;
            state     <= IDLE;
            rs1_valid <= '0;
            rs2_valid <= '0;
            slb_en    <= 1'b0;
            slb_full  <= 1'b0;
        end else if (rdy) begin
            slb_full <= (count == `OOO_SLB_NUM);
            slb_en   <= pop;
            if (dp_mem && !pop) begin
                count <= count + {{`OOO_SLB_PTR_W{1'b0}}, 1'b1};
            end else if (pop && !dp_mem) begin
                count <= count - {{`OOO_SLB_PTR_W{1'b0}}, 1'b1};
            end

            // stale entries may wake too, a push rewrites them
            for (int i = 0; i < `OOO_SLB_NUM; i++) begin
                if (!rs1_valid[i] && bus_hit(ent_rs1_nick[i])) begin
                    rs1_valid[i]  <= 1'b1;
                    ent_rs1_dt[i] <= bus_dt(ent_rs1_nick[i]);
                end
                if (!rs2_valid[i] && bus_hit(ent_rs2_nick[i])) begin
                    rs2_valid[i]  <= 1'b1;
                    ent_rs2_dt[i] <= bus_dt(ent_rs2_nick[i]);
                end
            end

            if (dp_mem) begin
                ent_op[tail]       <= dp_op;
                ent_imm[tail]      <= dp_imm;
                ent_rd_nick[tail]  <= dp_rd_nick;
                ent_rs1_nick[tail] <= dp_rs1_nick;
                ent_rs2_nick[tail] <= dp_rs2_nick;
                rs1_valid[tail]    <= (dp_rs1_nick == '0) || bus_hit(dp_rs1_nick);
                rs2_valid[tail]    <= (dp_rs2_nick == '0) || bus_hit(dp_rs2_nick);
                ent_rs1_dt[tail]   <= (dp_rs1_nick == '0) ? dp_rs1_dt : bus_dt(dp_rs1_nick);
                ent_rs2_dt[tail]   <= (dp_rs2_nick == '0) ? dp_rs2_dt : bus_dt(dp_rs2_nick);
                tail               <= tail + 1'b1;
            end

            case (state)
                IDLE: begin
                    if (count != '0) begin
                        state <= WAIT_OPS;
                    end
                end
                WAIT_OPS: begin
                    if (head_ready) begin
                        state <= ACCESS;
                    end
                end
                ACCESS: begin
                    head     <= head + 1'b1;
                    state    <= IDLE;
                    slb_nick <= ent_rd_nick[head];
                    // a store broadcasts the value it wrote
                    slb_dt   <= (ent_op[head] == LW) ? mem[head_idx] : ent_rs2_dt[head];
                end
                default: state <= IDLE;
            endcase
        end
    end

    // memory keeps its contents across rst and clr
    always_ff @(posedge clk) begin
        if (rdy && !(rst || clr) && pop && ent_op[head] == SW) begin
            mem[head_idx] <= ent_rs2_dt[head];
        end
    end

    a_no_push_full: assert property (@(posedge clk) disable iff (rst || clr)
        rdy && dp_mem |-> count < `OOO_SLB_NUM);

    a_slb_en_pulse: assert property (@(posedge clk) disable iff (rst)
        rdy && slb_en |=> !slb_en);

endmodule

//--- tb_ooo_core.sv
`timescale 1ns/100ps
`include "ooo_defs.svh"

module tb_ooo_core import ooo_pkg::*; ();

    logic  clk, rst, rdy, clr, dp_en;
    op_e   dp_op;
    addr_t dp_pc;
    imm_t  dp_imm;
    nick_t dp_rd_nick, dp_rs1_nick, dp_rs2_nick;
    data_t dp_rs1_dt, dp_rs2_dt;
    logic  rs_full, slb_full, ex_en, slb_en;
    nick_t ex_nick, slb_nick;
    data_t ex_dt, slb_dt;

    integer seed = 89516;
    int     cyc, err_cnt, test_cnt, test_fail, test_err0;
    // model state per nick
    bit     inflight [`OOO_RS_NUM];
    bit     is_mem   [`OOO_RS_NUM];
    data_t  expv     [`OOO_RS_NUM];
    int     disp_cyc [`OOO_RS_NUM];
    int     n_inflight, n_mem;
    nick_t  lat_nick, rd;
    nick_t  memq [$];
    data_t  mmem [`OOO_MEM_WORDS];
    int     words [$];

    ooo_core u_ooo_core (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic int rnd(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic data_t alu_model(input op_e op, input data_t a, input data_t b,
                                        input imm_t imm, input addr_t pc);
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SLL:     return a << b[4:0];
            SRL:     return a >> b[4:0];
            SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ADDI:    return a + imm;
            LUI:     return imm;
            default: return pc + imm;
        endcase
    endfunction

    task automatic check_bcast(input nick_t nick, input data_t dt, input bit from_slb,
                               input string sig);
        assert (inflight[nick]) else begin
            $display("unexpected broadcast of nick %0d at %0t", nick, $time);
            err_cnt++;
        end
        if (inflight[nick]) begin
            assert (dt == expv[nick]) else begin
                $display("** Error %0t %s actual %h expected %h", $time, sig, dt, expv[nick]);
                err_cnt++;
            end
            if (from_slb) begin
                assert (memq.size() > 0 && memq[0] == nick) else begin
                    $display("memory op nick %0d finished out of program order", nick);
                    err_cnt++;
                end
                if (memq.size() > 0) memq.pop_front();
            end
            if (nick == lat_nick) begin
                assert (cyc - disp_cyc[nick] == 2) else begin
                    $display("lone op took %0d cycles instead of 2", cyc - disp_cyc[nick]);
                    err_cnt++;
                end
            end
            inflight[nick] = 1'b0;
            n_inflight--;
            if (is_mem[nick]) n_mem--;
        end
    endtask

    // a broadcast counts in the cycle where rdy lets it be consumed
    always @(negedge clk) begin
        if (!rst && rdy) begin
            if (ex_en) check_bcast(ex_nick, ex_dt, 1'b0, "ex_dt");
            if (slb_en) check_bcast(slb_nick, slb_dt, 1'b1, "slb_dt");
        end
        cyc++;
    end

    task automatic wait_slot(input bit mem, output nick_t n);
        int t, s;
        n = '0;
        for (t = 0; t < 300 && n == '0; t++) begin
            @(posedge clk);
            s = rnd(15);
            for (int i = 0; i < 15; i++) begin
                if (n == '0 && !inflight[1 + (s + i) % 15]) n = nick_t'(1 + (s + i) % 15);
            end
            if (mem ? (n_mem >= `OOO_SLB_NUM || slb_full) : rs_full) n = '0;
            if (n == '0) dp_en <= 1'b0;
        end
        if (n == '0) begin
            $display("timeout while waiting for a free nick or queue entry");
            err_cnt++;
        end
    endtask

    task automatic pick_src(input bit dep, input nick_t force_n, output nick_t n,
                            output data_t d, output data_t val);
        int s;
        n = '0;
        d = $random(seed);
        if (force_n != '0) begin
            n = inflight[force_n] ? force_n : '0;
            val = expv[force_n];
            if (n == '0) d = val;
            return;
        end
        if (dep && rnd(2) == 1) begin
            s = rnd(15);
            for (int i = 0; i < 15; i++) begin
                if (n == '0 && inflight[1 + (s + i) % 15]) n = nick_t'(1 + (s + i) % 15);
            end
        end
        val = (n == '0) ? d : expv[n];
    endtask

    task automatic issue(input op_e op, input addr_t pc, input imm_t imm, input nick_t n,
                         input nick_t n1, input data_t d1, input nick_t n2, input data_t d2,
                         input data_t ev);
        dp_en       <= 1'b1;
        dp_op       <= op;
        dp_pc       <= pc;
        dp_imm      <= imm;
        dp_rd_nick  <= n;
        dp_rs1_nick <= n1;
        dp_rs1_dt   <= d1;
        dp_rs2_nick <= n2;
        dp_rs2_dt   <= d2;
        inflight[n] = 1'b1;
        is_mem[n]   = op inside {LW, SW};
        expv[n]     = ev;
        disp_cyc[n] = cyc + 1;
        n_inflight++;
        if (is_mem[n]) begin
            n_mem++;
            memq.push_back(n);
        end
    endtask

    task automatic arith_op(input bit dep, input nick_t force_n, output nick_t n);
        nick_t n1, n2;
        data_t d1, d2, v1, v2;
        op_e   op;
        imm_t  imm;
        addr_t pc;
        wait_slot(1'b0, n);
        if (n == '0) return;
        op  = op_e'(rnd(11));
        imm = $random(seed);
        pc  = {$random(seed)} & 32'hffff_fffc;
        pick_src(dep, force_n, n1, d1, v1);
        pick_src(dep, '0, n2, d2, v2);
        issue(op, pc, imm, n, n1, d1, n2, d2, alu_model(op, v1, v2, imm, pc));
    endtask

    task automatic mem_op(input bit store, input bit dep, input nick_t force_n);
        nick_t n, n1, n2;
        data_t d1, d2, v1, v2;
        imm_t  imm;
        int    w;
        wait_slot(1'b1, n);
        if (n == '0) return;
        if (words.size() == 0) store = 1'b1;
        pick_src(dep, force_n, n1, d1, v1);
        pick_src(dep, '0, n2, d2, v2);
        w = store ? rnd(`OOO_MEM_WORDS) : words[rnd(words.size())];
        // upper address bits are random, only bits 7:2 select the word
        imm = imm_t'(w * 4) + ({$random(seed)} & 32'hffff_ff00) - v1;
        if (store) begin
            if (!(w inside {words})) words.push_back(w);
            mmem[w] = v2;
            issue(SW, '0, imm, n, n1, d1, n2, d2, v2);
        end else begin
            issue(LW, '0, imm, n, n1, d1, n2, d2, mmem[w]);
        end
    endtask

    // all other slots wait on the last nick, so the station fills up
    task automatic fill_station();
        nick_t prod;
        data_t a, b, d, pv;
        op_e   op;
        imm_t  imm;
        prod = nick_t'(`OOO_RS_NUM - 1);
        a    = $random(seed);
        b    = $random(seed);
        pv   = alu_model(ADD, a, b, '0, '0);
        for (int i = 1; i < `OOO_RS_NUM - 1; i++) begin
            @(posedge clk);
            op  = op_e'(rnd(11));
            imm = $random(seed);
            d   = $random(seed);
            issue(op, '0, imm, nick_t'(i), prod, '0, '0, d, alu_model(op, pv, d, imm, '0));
        end
        @(posedge clk);
        issue(ADD, '0, '0, prod, '0, a, '0, b, pv);
        @(posedge clk);
        dp_en <= 1'b0;
    endtask

    task automatic drain();
        int t;
        @(posedge clk);
        dp_en <= 1'b0;
        for (t = 0; t < 500 && n_inflight > 0; t++) @(posedge clk);
        if (n_inflight > 0) begin
            $display("timeout: %0d instructions were never broadcast", n_inflight);
            err_cnt++;
        end
        repeat (4) @(posedge clk);
    endtask

    task automatic wait_full(input bit station, input logic level);
        int t;
        t = 0;
        do begin
            @(negedge clk);
            t++;
        end while (t < 200 && (station ? rs_full : slb_full) !== level);
        assert ((station ? rs_full : slb_full) === level) else begin
            $display("timeout: %s never went to %b", station ? "rs_full" : "slb_full", level);
            err_cnt++;
        end
    endtask

    task automatic stall(input int len);
        repeat (len) begin
            @(posedge clk);
            rdy   <= 1'b0;
            dp_en <= 1'b0;
        end
        @(posedge clk);
        rdy <= 1'b1;
    endtask

    task automatic random_mix(input int num, input bit stalls);
        repeat (num) begin
            if (stalls && rnd(4) == 0) stall(1 + rnd(5));
            else if (rnd(4) == 0) mem_op(rnd(2), 1'b1, '0);
            else arith_op(1'b1, '0, rd);
        end
    endtask

    task automatic end_test(input string name);
        test_cnt++;
        if (err_cnt != test_err0) test_fail++;
        $display("%s: %s", name, (err_cnt == test_err0) ? "ok" : "FAILED");
        test_err0 = err_cnt;
    endtask

    initial begin
        #5_000_000;
        $display("watchdog expired, simulation stopped");
        $display("Test failed");
        $finish;
    end

    initial begin
        {rst, rdy, clr, dp_en} = 4'b1100;
        {dp_pc, dp_imm, dp_rs1_dt, dp_rs2_dt} = '0;
        {dp_rd_nick, dp_rs1_nick, dp_rs2_nick} = '0;
        dp_op = ADD;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        repeat (6) begin
            arith_op(1'b0, '0, rd);
            lat_nick = rd;
            drain();
        end
        lat_nick = '0;
        repeat (12) arith_op(1'b0, '0, rd);
        drain();
        end_test("independent ops");

        random_mix(80, 1'b0);
        drain();
        end_test("dependent chains");

        repeat (6) mem_op(1'b1, 1'b1, '0);
        repeat (12) mem_op(rnd(3) == 0, 1'b1, '0);
        drain();
        end_test("store and load");

        random_mix(80, 1'b1);
        drain();
        end_test("rdy stalls");

        repeat (4) mem_op(1'b1, 1'b0, '0);
        drain();
        repeat (8) arith_op(1'b1, '0, rd);
        // loads still queued when the flush hits
        repeat (2) mem_op(1'b0, 1'b1, '0);
        @(posedge clk);
        clr   <= 1'b1;
        dp_en <= 1'b0;
        @(posedge clk);
        clr <= 1'b0;
        foreach (inflight[i]) inflight[i] = 1'b0;
        {n_inflight, n_mem} = '0;
        memq.delete();
        // any broadcast here is flagged by the monitor
        repeat (20) @(posedge clk);
        repeat (6) mem_op(1'b0, 1'b1, '0);
        random_mix(10, 1'b0);
        drain();
        end_test("clear");

        // loads stall behind a slow chain so the buffer fills
        arith_op(1'b0, '0, rd);
        repeat (3) arith_op(1'b1, rd, rd);
        repeat (`OOO_SLB_NUM) mem_op(1'b0, 1'b1, rd);
        @(posedge clk);
        dp_en <= 1'b0;
        wait_full(1'b0, 1'b1);
        assert (!rs_full) else begin
            $display("rs_full high with fewer than 15 slots in use");
            err_cnt++;
        end
        wait_full(1'b0, 1'b0);
        drain();
        fill_station();
        wait_full(1'b1, 1'b1);
        wait_full(1'b1, 1'b0);
        drain();
        end_test("full levels");

        $display("%0d tests, %0d failed, %0d errors", test_cnt, test_fail, err_cnt);
        if (err_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
